/* all.f */
rtl/bomb_pkg.sv
rtl/bomb_placer.sv
rtl/bomb_timer.sv
rtl/blast_resolver.sv
rtl/bomb_field.sv
bench/field_clock.sv
bench/field_checker.sv
bench/field_tb.sv

/* Bender.yml */
package:
  name: bomb_field

# Design sources in compile order
sources:
  - rtl/bomb_pkg.sv
  - rtl/bomb_placer.sv
  - rtl/bomb_timer.sv
  - rtl/blast_resolver.sv
  - rtl/bomb_field.sv

  # Testbench, top module field_tb
  - target: test
    files:
      - bench/field_clock.sv
      - bench/field_checker.sv
      - bench/field_tb.sv

/* bench/field_tb.sv */
// Testbench top with reset, frame ticks, LFSR stimulus, directed and random placements
`timescale 1ns/1ps
`default_nettype none

module field_tb;
	import bomb_pkg::*;

	localparam int NUM_SLOTS    = 4;
	localparam int WAIT_LIMIT   = 600; // Cycles per wait
	localparam int ANSWER_LIMIT = 4;   // Cycles for a placement answer

	logic       Clk;
	logic       rst;
	logic       frame_tick;
	logic       place_req;
	logic       query_en;
	tile_row_t  place_row, player_row, query_row, blast_row;
	tile_col_t  place_col, player_col, query_col, blast_col;
	logic       place_ack, place_reject, blast_done, player_hit;
	tile_kind_t query_kind;
	int         error_count;
	int         pending_count;
	int         timeout_count;
	logic       aborted;   // Set by a timeout so that later steps skip their waits
	logic [15:0] lfsr;

	field_clock clk_gen (.Clk);

	bomb_field #(.NUM_SLOTS(NUM_SLOTS), .FUSE_FRAMES(3), .BLAST_FRAMES(2)) uut (
		.Clk, .rst, .frame_tick, .place_req, .place_row, .place_col,
		.player_row, .player_col, .query_row, .query_col,
		.place_ack, .place_reject, .blast_done, .player_hit,
		.blast_row, .blast_col, .query_kind
	);

	field_checker #(.NUM_SLOTS(NUM_SLOTS)) scoreboard (
		.Clk, .rst, .place_req, .place_row, .place_col, .player_row, .player_col,
		.query_en, .query_row, .query_col, .place_ack, .place_reject,
		.blast_done, .player_hit, .blast_row, .blast_col, .query_kind,
		.error_count, .pending_count
	);

	// One frame tick every 8 cycles
	initial
	begin
		frame_tick = 1'b0;
		forever
		begin
			repeat (7) @(posedge Clk);
			#1 frame_tick = 1'b1;
			@(posedge Clk);
			#1 frame_tick = 1'b0;
		end
	end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr  = lfsr_next(lfsr);
			value = (value << 1) | lfsr[0];
		end
	endtask

	task automatic report_timeout(input string what, input int limit);
		timeout_count++;
		aborted = 1'b1;
		$display("Timeout at %0t: no %s within %0d cycles", $time, what, limit);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge Clk);
			#1;
		end
	endtask

	// One-cycle request and a wait for the answer
	task automatic place_bomb(input int row, input int col);
		int cycles;
		cycles    = 0;
		place_row = tile_row_t'(row);
		place_col = tile_col_t'(col);
		place_req = 1'b1;
		@(posedge Clk);
		#1 place_req = 1'b0;
		while (!aborted && !(place_ack || place_reject) && cycles < ANSWER_LIMIT)
		begin
			@(posedge Clk);
			#1;
			cycles++;
		end
		if (!aborted && !(place_ack || place_reject))
			report_timeout("placement answer", ANSWER_LIMIT);
	endtask

	task automatic wait_blast();
		int cycles;
		cycles = 0;
		while (!aborted && !blast_done && cycles < WAIT_LIMIT)
		begin
			@(posedge Clk);
			#1;
			cycles++;
		end
		if (!aborted && !blast_done)
			report_timeout("blast_done", WAIT_LIMIT);
		else
			idle_cycles(1); // Past the credit return
	endtask

	task automatic drain_pending();
		int cycles;
		cycles = 0;
		while (!aborted && pending_count != 0 && cycles < WAIT_LIMIT)
		begin
			@(posedge Clk);
			#1;
			cycles++;
		end
		if (!aborted && pending_count != 0)
			report_timeout("end of all pending blasts", WAIT_LIMIT);
	endtask

	// Sweeps every map tile
	task automatic query_all();
		query_en = 1'b1;
		for (int r = 0; r < MAP_ROWS; r++)
			for (int c = 0; c < MAP_COLS; c++)
			begin
				query_row = tile_row_t'(r);
				query_col = tile_col_t'(c);
				idle_cycles(1);
			end
		query_en = 1'b0;
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		int row;
		int col;
		int gap;
		rst           = 1'b1;
		place_req     = 1'b0;
		place_row     = '0;
		place_col     = '0;
		player_row    = 4'd2;
		player_col    = 4'd1;
		query_en      = 1'b0;
		query_row     = '0;
		query_col     = '0;
		aborted       = 1'b0;
		timeout_count = 0;
		lfsr          = 16'd51344;
		repeat (8) @(posedge Clk);
		#1 rst = 1'b0;

		query_all(); // Reset map

		// Single bomb with the player just below it
		place_bomb(1, 1);
		wait_blast();
		drain_pending();
		query_all();

		// Fill every slot and then one too many
		player_row = 4'd10;
		player_col = 4'd14;
		place_bomb(1, 3);
		place_bomb(1, 4);
		place_bomb(3, 1);
		place_bomb(1, 7);
		place_bomb(5, 5);
		wait_blast();
		place_bomb(5, 5); // Credit is back
		drain_pending();

		// Brick, wall and off-map tiles
		place_bomb(3, 3);
		place_bomb(2, 2);
		place_bomb(13, 2);

		// Random traffic
		player_row = 4'd4;
		player_col = 4'd5;
		for (int n = 0; n < 60; n++)
		begin
			draw_bits(4, row);
			draw_bits(4, col);
			place_bomb(row, col);
			draw_bits(3, gap);
			idle_cycles(gap);
		end
		drain_pending();
		query_all();

		$display("Check errors: %0d, timeouts: %0d", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/field_checker.sv */
// Scoreboard with reference map model, blast reference function and output checks
`timescale 1ns/1ps
`default_nettype none

module field_checker #(
	parameter int NUM_SLOTS = 4
) (
	input  wire logic                 Clk,
	input  wire logic                 rst,
	input  wire logic                 place_req,
	input  wire bomb_pkg::tile_row_t  place_row,
	input  wire bomb_pkg::tile_col_t  place_col,
	input  wire bomb_pkg::tile_row_t  player_row,
	input  wire bomb_pkg::tile_col_t  player_col,
	input  wire logic                 query_en,
	input  wire bomb_pkg::tile_row_t  query_row,
	input  wire bomb_pkg::tile_col_t  query_col,
	input  wire logic                 place_ack,
	input  wire logic                 place_reject,
	input  wire logic                 blast_done,
	input  wire logic                 player_hit,
	input  wire bomb_pkg::tile_row_t  blast_row,
	input  wire bomb_pkg::tile_col_t  blast_col,
	input  wire bomb_pkg::tile_kind_t query_kind,
	output int                        error_count,
	output int                        pending_count
);
	import bomb_pkg::*;

	// Answer owed to the request of the previous cycle
	typedef enum logic [1:0] {EXP_NONE, EXP_ACK, EXP_REJECT, EXP_EITHER} expect_t;

	tile_kind_t model_map [MAP_ROWS][MAP_COLS];
	int         pend_r[$]; // Accepted bombs not yet blasted
	int         pend_c[$];
	int         req_r;
	int         req_c;
	expect_t    expected;

	initial error_count = 0;

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic tile_kind_t rule_tile(input int r, input int c);
		logic border;
		logic pillar;
		border = (r == 0) || (r == MAP_ROWS - 1) || (c == 0) || (c == MAP_COLS - 1);
		pillar = (r % 2 == 0) && (c % 2 == 0);
		if (border || pillar)
			return TILE_WALL;
		return ((r + c) % 3 == 0) ? TILE_BRICK : TILE_GROUND;
	endfunction

	// Anything off the map reads as wall
	function automatic tile_kind_t model_tile(input int r, input int c);
		if (r < 0 || r >= MAP_ROWS || c < 0 || c >= MAP_COLS)
			return TILE_WALL;
		return model_map[r][c];
	endfunction

	function automatic logic in_cross(input int r, input int c, input int br, input int bc);
		return (r == br && c >= bc - BLAST_RANGE && c <= bc + BLAST_RANGE)
			|| (c == bc && r >= br - BLAST_RANGE && r <= br + BLAST_RANGE);
	endfunction

	// Clears bricks in the cross and returns the expected player hit
	function automatic logic apply_blast(input int br, input int bc, input int pr, input int pc);
		int   r;
		int   c;
		logic hit;
		hit = 1'b0;
		for (r = br - BLAST_RANGE; r <= br + BLAST_RANGE; r++)
			for (c = bc - BLAST_RANGE; c <= bc + BLAST_RANGE; c++)
				if (in_cross(r, c, br, bc) && r >= 0 && r < MAP_ROWS && c >= 0 && c < MAP_COLS)
				begin
					if (model_map[r][c] == TILE_BRICK)
						model_map[r][c] = TILE_GROUND;
					if (r == pr && c == pc)
						hit = 1'b1;
				end
		return hit;
	endfunction

	// A brick here may already be gone while a scan runs
	function automatic logic near_pending(input int r, input int c);
		for (int i = 0; i < pend_r.size(); i++)
			if (in_cross(r, c, pend_r[i], pend_c[i]))
				return 1'b1;
		return 1'b0;
	endfunction

	////////////////////////////////////////
	// Comparison
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			error_count++;
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic score_response();
		if (expected == EXP_EITHER)
		begin
			if (place_ack === place_reject)
			begin
				error_count++;
				$display("At %0t the placement got no single ack or reject", $time);
			end
		end
		else
		begin
			check_value("place_ack", place_ack, expected == EXP_ACK);
			check_value("place_reject", place_reject, expected == EXP_REJECT);
		end
		if (expected != EXP_NONE && place_ack === 1'b1)
		begin
			pend_r.push_back(req_r);
			pend_c.push_back(req_c);
		end
	endtask

	task automatic predict_request();
		tile_kind_t kind;
		req_r = int'(place_row);
		req_c = int'(place_col);
		kind  = model_tile(req_r, req_c);
		if (!place_req)
			expected = EXP_NONE;
		else if (pend_r.size() >= NUM_SLOTS)
			expected = EXP_REJECT; // Out of credits
		else if (kind == TILE_GROUND)
			expected = EXP_ACK;
		else if (kind == TILE_BRICK && near_pending(req_r, req_c))
			expected = EXP_EITHER;
		else
			expected = EXP_REJECT;
	endtask

	task automatic retire_bomb();
		int   idx;
		logic exp_hit;
		idx = -1;
		for (int i = 0; i < pend_r.size(); i++)
			if (idx < 0 && pend_r[i] == int'(blast_row) && pend_c[i] == int'(blast_col))
				idx = i;
		if (idx < 0)
		begin
			error_count++;
			$display("At %0t blast_done reported tile (%0d,%0d) where no bomb was pending",
				$time, blast_row, blast_col);
		end
		else
		begin
			pend_r.delete(idx);
			pend_c.delete(idx);
			exp_hit = apply_blast(int'(blast_row), int'(blast_col),
				int'(player_row), int'(player_col));
			check_value("player_hit", player_hit, exp_hit);
		end
	endtask

	// A credit or map change seen now only counts from the next cycle
	always @(posedge Clk)
	begin
		if (rst)
		begin
			for (int r = 0; r < MAP_ROWS; r++)
				for (int c = 0; c < MAP_COLS; c++)
					model_map[r][c] = rule_tile(r, c);
			pend_r.delete();
			pend_c.delete();
			expected = EXP_NONE;
		end
		else
		begin
			score_response();
			if (query_en)
				check_value("query_kind", query_kind,
					model_tile(int'(query_row), int'(query_col)));
			predict_request();
			if (blast_done === 1'b1)
				retire_bomb();
			else
			begin
				check_value("blast_done", blast_done, 1'b0);
				check_value("player_hit", player_hit, 1'b0); // Only with blast_done
			end
		end
		pending_count = pend_r.size();
	end

endmodule

`default_nettype wire

/* bench/field_clock.sv */
// Free-running testbench clock generator
`timescale 1ns/1ps
`default_nettype none

module field_clock #(
	parameter realtime PERIOD = 10ns
) (
	output logic Clk
);
	initial Clk = 1'b0;

	always #(PERIOD / 2) Clk = ~Clk; // 10 ns period

endmodule

`default_nettype wire

/* rtl/bomb_field.sv */
// Bomb field top level with placer, timer slots and blast resolver
`timescale 1ns/1ps
`default_nettype none

module bomb_field #(
	parameter  int NUM_SLOTS    = 4,
	parameter  int FUSE_FRAMES  = 3,
	parameter  int BLAST_FRAMES = 2,
	localparam int SLOT_W       = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1
) (
	input  wire logic            Clk,
	input  wire logic            rst,
	input  wire logic            frame_tick,
	input  wire logic            place_req,
	input  bomb_pkg::tile_row_t  place_row,
	input  bomb_pkg::tile_col_t  place_col,
	input  bomb_pkg::tile_row_t  player_row,
	input  bomb_pkg::tile_col_t  player_col,
	input  bomb_pkg::tile_row_t  query_row,
	input  bomb_pkg::tile_col_t  query_col,
	output logic                 place_ack,
	output logic                 place_reject,
	output logic                 blast_done,
	output logic                 player_hit,
	output bomb_pkg::tile_row_t  blast_row,
	output bomb_pkg::tile_col_t  blast_col,
	output bomb_pkg::tile_kind_t query_kind
);
	import bomb_pkg::*;

	logic [NUM_SLOTS-1:0] slot_load, resolve_req, resolve_ack;
	logic                 credit_valid;
	logic [SLOT_W-1:0]    credit_slot;
	tile_kind_t           place_kind;   // Tile under the placement request
	tile_row_t            bomb_row;
	tile_col_t            bomb_col;
	tile_row_t [NUM_SLOTS-1:0] slot_rows;
	tile_col_t [NUM_SLOTS-1:0] slot_cols;

	bomb_placer #(.NUM_SLOTS(NUM_SLOTS)) placer (
		.Clk, .rst, .place_req, .place_row, .place_col, .place_kind,
		.credit_valid, .credit_slot, .place_ack, .place_reject,
		.slot_load, .bomb_row, .bomb_col
	);

	// One timer per credit
	for (genvar i = 0; i < NUM_SLOTS; i++)
	begin : g_slot
		bomb_timer #(.FUSE_FRAMES(FUSE_FRAMES), .BLAST_FRAMES(BLAST_FRAMES)) timer (
			.Clk, .rst, .frame_tick,
			.load(slot_load[i]), .bomb_row, .bomb_col,
			.resolve_ack(resolve_ack[i]), .resolve_req(resolve_req[i]),
			.slot_row(slot_rows[i]), .slot_col(slot_cols[i])
		);
	end

	blast_resolver #(.NUM_SLOTS(NUM_SLOTS)) resolver (
		.Clk, .rst, .resolve_req, .slot_rows, .slot_cols,
		.player_row, .player_col, .place_row, .place_col, .query_row, .query_col,
		.resolve_ack, .credit_valid, .credit_slot, .blast_done,
		.blast_row, .blast_col, .player_hit, .place_kind, .query_kind
	);

endmodule

`default_nettype wire

/* rtl/blast_resolver.sv */
// Blast resolver with tile map, cross scan FSM, player hit, credit return and read ports
`timescale 1ns/1ps
`default_nettype none

module blast_resolver #(
	parameter  int NUM_SLOTS = 4,
	localparam int SLOT_W    = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1
) (
	input  wire logic                            Clk,
	input  wire logic                            rst,
	input  wire logic [NUM_SLOTS-1:0]            resolve_req,
	input  bomb_pkg::tile_row_t [NUM_SLOTS-1:0]  slot_rows,
	input  bomb_pkg::tile_col_t [NUM_SLOTS-1:0]  slot_cols,
	input  bomb_pkg::tile_row_t                  player_row,
	input  bomb_pkg::tile_col_t                  player_col,
	input  bomb_pkg::tile_row_t                  place_row,
	input  bomb_pkg::tile_col_t                  place_col,
	input  bomb_pkg::tile_row_t                  query_row,
	input  bomb_pkg::tile_col_t                  query_col,
	output logic [NUM_SLOTS-1:0]                 resolve_ack,
	output logic                                 credit_valid,
	output logic [SLOT_W-1:0]                    credit_slot,
	output logic                                 blast_done,
	output bomb_pkg::tile_row_t                  blast_row,
	output bomb_pkg::tile_col_t                  blast_col,
	output logic                                 player_hit,
	output bomb_pkg::tile_kind_t                 place_kind,
	output bomb_pkg::tile_kind_t                 query_kind
);
	import bomb_pkg::*;

	typedef enum logic [2:0] {
		SCAN_IDLE,
		SCAN_CENTRE,
		SCAN_UP,
		SCAN_DOWN,
		SCAN_LEFT,
		SCAN_RIGHT
	} scan_state_t;

	tile_kind_t  map_q [MAP_ROWS][MAP_COLS];
	scan_state_t state;
	logic [SLOT_W-1:0] cur_slot, pick_slot;
	logic        hit_q, hit_now, in_map, last_tile;
	int          cross_r, cross_c; // Signed since it may fall off the map

	// Wall border, even/even pillars, bricks on every third diagonal
	function automatic tile_kind_t reset_tile(input int r, input int c);
		if (r == 0 || r == MAP_ROWS - 1 || c == 0 || c == MAP_COLS - 1)
			return TILE_WALL;
		if (r % 2 == 0 && c % 2 == 0)
			return TILE_WALL;
		if ((r + c) % 3 == 0)
			return TILE_BRICK;
		return TILE_GROUND;
	endfunction

	// Off-map reads look like wall
	function automatic tile_kind_t read_tile(input tile_row_t r, input tile_col_t c);
		if (int'(r) >= MAP_ROWS || int'(c) >= MAP_COLS)
			return TILE_WALL;
		return map_q[r][c];
	endfunction

	always_comb place_kind = read_tile(place_row, place_col);
	always_comb query_kind = read_tile(query_row, query_col);

	// Lowest requesting slot
	always_comb
	begin
		pick_slot = '0;
		for (int i = NUM_SLOTS - 1; i >= 0; i--)
			if (resolve_req[i])
				pick_slot = SLOT_W'(i);
	end

	////////////////////////////////////////
	// Current tile of the cross
	////////////////////////////////////////

	always_comb
	begin
		cross_r = int'(blast_row);
		cross_c = int'(blast_col);
		case (state)
			SCAN_UP:    cross_r = int'(blast_row) - BLAST_RANGE;
			SCAN_DOWN:  cross_r = int'(blast_row) + BLAST_RANGE;
			SCAN_LEFT:  cross_c = int'(blast_col) - BLAST_RANGE;
			SCAN_RIGHT: cross_c = int'(blast_col) + BLAST_RANGE;
			default:    ;
		endcase
	end

	assign in_map = (state != SCAN_IDLE) && cross_r >= 0 && cross_r < MAP_ROWS
		&& cross_c >= 0 && cross_c < MAP_COLS;
	assign hit_now = in_map && cross_r == int'(player_row) && cross_c == int'(player_col);
	assign last_tile = (state == SCAN_RIGHT);

	// End of scan strobes
	assign blast_done   = last_tile;
	assign credit_valid = last_tile;
	assign credit_slot  = cur_slot;
	assign resolve_ack  = last_tile ? (NUM_SLOTS'(1) << cur_slot) : '0;
	assign player_hit   = last_tile && (hit_q || hit_now);

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			state <= SCAN_IDLE;
			hit_q <= 1'b0;
		end
		else
		begin
			hit_q <= (state == SCAN_IDLE) ? 1'b0 : (hit_q | hit_now);
			unique case (state)
				SCAN_IDLE:   if (|resolve_req) state <= SCAN_CENTRE;
				SCAN_CENTRE: state <= SCAN_UP;
				SCAN_UP:     state <= SCAN_DOWN;
				SCAN_DOWN:   state <= SCAN_LEFT;
				SCAN_LEFT:   state <= SCAN_RIGHT;
				SCAN_RIGHT:  state <= SCAN_IDLE;
				default:     state <= SCAN_IDLE;
			endcase
		end
	end

	// Latch the accepted bomb
	always_ff @(posedge Clk)
	begin
		if (state == SCAN_IDLE && (|resolve_req))
		begin
			cur_slot  <= pick_slot;
			blast_row <= slot_rows[pick_slot];
			blast_col <= slot_cols[pick_slot];
		end
	end

	////////////////////////////////////////
	// Tile map
	////////////////////////////////////////

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			for (int r = 0; r < MAP_ROWS; r++)
				for (int c = 0; c < MAP_COLS; c++)
					map_q[r][c] <= reset_tile(r, c);
		end
		else if (in_map && map_q[tile_row_t'(cross_r)][tile_col_t'(cross_c)] == TILE_BRICK)
			map_q[tile_row_t'(cross_r)][tile_col_t'(cross_c)] <= TILE_GROUND; // Brick destroyed
	end

endmodule

`default_nettype wire

/* rtl/bomb_timer.sv */
// Single bomb timer with fuse and explosion FSM and the stored bomb tile
`timescale 1ns/1ps
`default_nettype none

module bomb_timer #(
	parameter int FUSE_FRAMES  = 3,
	parameter int BLAST_FRAMES = 2
) (
	input  wire logic           Clk,
	input  wire logic           rst,
	input  wire logic           frame_tick,
	input  wire logic           load,
	input  bomb_pkg::tile_row_t bomb_row,
	input  bomb_pkg::tile_col_t bomb_col,
	input  wire logic           resolve_ack,
	output logic                resolve_req,
	output bomb_pkg::tile_row_t slot_row,
	output bomb_pkg::tile_col_t slot_col
);
	import bomb_pkg::*;

	typedef enum logic [1:0] {
		T_IDLE,
		T_FUSED,
		T_EXPLODING,
		T_WAITING
	} timer_state_t;

	timer_state_t state;
	frame_cnt_t   frame_cnt;

	// Held until the resolver answers
	assign resolve_req = (state == T_WAITING);

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			state     <= T_IDLE;
			frame_cnt <= '0;
		end
		else
		begin
			unique case (state)
				T_IDLE:
				begin
					if (load)
					begin
						state     <= T_FUSED;
						frame_cnt <= '0;
					end
				end
				T_FUSED:
				begin
					if (frame_tick)
					begin
						if (frame_cnt == frame_cnt_t'(FUSE_FRAMES - 1))
						begin
							state     <= T_EXPLODING;
							frame_cnt <= '0;
						end
						else
							frame_cnt <= frame_cnt + 1'b1;
					end
				end
				T_EXPLODING:
				begin
					if (frame_tick)
					begin
						if (frame_cnt == frame_cnt_t'(BLAST_FRAMES - 1))
							state <= T_WAITING; // Hand over to the resolver
						else
							frame_cnt <= frame_cnt + 1'b1;
					end
				end
				T_WAITING:
				begin
					if (resolve_ack)
						state <= T_IDLE;
				end
				default: state <= T_IDLE;
			endcase
		end
	end

	// Tile of this bomb
	always_ff @(posedge Clk)
	begin
		if (load && state == T_IDLE)
		begin
			slot_row <= bomb_row;
			slot_col <= bomb_col;
		end
	end

endmodule

`default_nettype wire

/* rtl/bomb_placer.sv */
// Bomb placer with free-slot credit pool and lowest free slot selection
`timescale 1ns/1ps
`default_nettype none

module bomb_placer #(
	parameter  int NUM_SLOTS = 4,
	localparam int SLOT_W    = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1
) (
	input  wire logic                 Clk,
	input  wire logic                 rst,
	input  wire logic                 place_req,
	input  bomb_pkg::tile_row_t       place_row,
	input  bomb_pkg::tile_col_t       place_col,
	input  bomb_pkg::tile_kind_t      place_kind,   // Map tile under the request
	input  wire logic                 credit_valid,
	input  wire logic [SLOT_W-1:0]    credit_slot,
	output logic                      place_ack,
	output logic                      place_reject,
	output logic [NUM_SLOTS-1:0]      slot_load,
	output bomb_pkg::tile_row_t       bomb_row,
	output bomb_pkg::tile_col_t       bomb_col
);
	import bomb_pkg::*;

	logic [NUM_SLOTS-1:0] free_mask;   // One bit per credit
	logic [NUM_SLOTS-1:0] lowest_free;
	logic [NUM_SLOTS-1:0] taken;
	logic [NUM_SLOTS-1:0] returned;
	logic                 accept;

	// Isolate the lowest set bit of the free mask
	assign lowest_free = free_mask & (~free_mask + 1'b1);

	// Needs a credit and a ground tile
	assign accept = place_req && (|free_mask) && (place_kind == TILE_GROUND);

	assign taken    = accept ? lowest_free : '0;
	assign returned = credit_valid ? (NUM_SLOTS'(1) << credit_slot) : '0;

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			free_mask    <= '1; // All slots free
			place_ack    <= 1'b0;
			place_reject <= 1'b0;
			slot_load    <= '0;
		end
		else
		begin
			place_ack    <= accept;
			place_reject <= place_req && !accept;
			slot_load    <= taken;
			// Returned credit only counts from the next cycle on
			free_mask    <= (free_mask & ~taken) | returned;
		end
	end

	// Coordinates shared by all timers and sampled with the load pulse
	always_ff @(posedge Clk)
	begin
		if (accept)
		begin
			bomb_row <= place_row;
			bomb_col <= place_col;
		end
	end

endmodule

`default_nettype wire

/* rtl/bomb_pkg.sv */
// Map dimensions, tile codes, blast reach and the shared vector types
`default_nettype none

package bomb_pkg;

	////////////////////////////////////////
	// Map geometry
	////////////////////////////////////////

	localparam int MAP_ROWS = 12; // Tile rows
	localparam int MAP_COLS = 16; // Tile columns

	// Reach of a blast in each direction
	localparam int BLAST_RANGE = 1;

	////////////////////////////////////////
	// Vector types
	////////////////////////////////////////

	typedef logic [3:0] tile_row_t;  // Row index
	typedef logic [3:0] tile_col_t;  // Column index
	typedef logic [1:0] tile_kind_t; // Tile code
	typedef logic [3:0] frame_cnt_t; // Frame tick counter

	// Tile codes as stored in the map
	localparam tile_kind_t TILE_GROUND = 2'd0;
	localparam tile_kind_t TILE_BRICK  = 2'd1;
	localparam tile_kind_t TILE_WALL   = 2'd2;

endpackage

`default_nettype wire
